// File: Bender.yml
package:
  name: int_exec_unit

sources:
  - verilog/rv_exec_pkg.sv
  - verilog/instr_decoder.sv
  - verilog/register_file.sv
  - verilog/int_alu.sv
  - verilog/writeback_stage.sv
  - verilog/int_exec_unit.sv
  - target: test
    files:
      - test/tb_int_exec_unit.sv

// File: flist.f
verilog/rv_exec_pkg.sv
verilog/instr_decoder.sv
verilog/register_file.sv
verilog/int_alu.sv
verilog/writeback_stage.sv
verilog/int_exec_unit.sv
test/tb_int_exec_unit.sv

// File: test/tb_int_exec_unit.sv
// Directed testbench for the integer execution unit.
// Holds a shadow register model, instruction encoders, the value check and the tests.

`timescale 1ns/10ps
`default_nettype none

module tb_int_exec_unit;

  localparam int TIMEOUT_CYCLES = 20;
  localparam int CHAIN_LEN      = 8;

  logic                   clk_i;
  logic                   rst_n_i;
  logic                   instr_valid_i;
  rv_exec_pkg::instr_u    instr_i;
  logic                   result_valid_o;
  rv_exec_pkg::reg_addr_t result_rd_o;
  rv_exec_pkg::xlen_t     result_o;
  logic                   illegal_o;

  // architectural state as the ISA defines it, x0 is kept at zero.
  logic [31:0] shadow [32];
  integer      seed;

  int_exec_unit u_dut (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .instr_valid_i  (instr_valid_i),
    .instr_i        (instr_i),
    .result_valid_o (result_valid_o),
    .result_rd_o    (result_rd_o),
    .result_o       (result_o),
    .illegal_o      (illegal_o)
  );

  always #10 clk_i = ~clk_i;

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("SOME TESTS FAILED");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      fail_run($sformatf("mismatch %s: got 0x%08h, expected 0x%08h", name, actual, expected));
    end
  endtask

  function automatic logic [31:0] encode_r(input logic [6:0] funct7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] funct3,
                                           input logic [4:0] rd);
    return {funct7, rs2, rs1, funct3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] encode_i(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] funct3, input logic [4:0] rd);
    return {imm, rs1, funct3, rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] sign_extend(input logic [11:0] imm);
    return {{20{imm[11]}}, imm};
  endfunction

  // RV32I semantics; signed compare by flipping the sign bits, arithmetic shift by fill mask.
  function automatic logic [31:0] expected_alu(input logic [2:0] funct3, input logic alt,
                                               input logic [31:0] a, input logic [31:0] b);
    logic [4:0]  sh;
    logic [31:0] fill;
    sh   = b[4:0];
    fill = a[31] ? ~(32'hffff_ffff >> sh) : 32'h0;
    case (funct3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << sh;
      3'd2:    return {31'b0, (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)};
      3'd3:    return {31'b0, a < b};
      3'd4:    return a ^ b;
      3'd5:    return alt ? ((a >> sh) | fill) : (a >> sh);
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic [4:0] pick_reg();
    return 5'd1 + 5'({$random(seed)} % 31);
  endfunction

  // strobes one instruction and waits for either output pulse.
  task automatic issue(input logic [31:0] word);
    int waited;
    @(posedge clk_i);
    #2;
    instr_valid_i = 1'b1;
    instr_i       = word;
    waited        = 0;
    do begin
      @(posedge clk_i);
      #2;
      instr_valid_i = 1'b0;
      waited++;
      if (waited > TIMEOUT_CYCLES) begin
        fail_run("timeout, neither result_valid_o nor illegal_o rose after a strobe");
      end
    end while (!(result_valid_o || illegal_o));
  endtask

  task automatic run_legal(input logic [31:0] word, input logic [4:0] rd,
                           input logic [31:0] expected);
    issue(word);
    check_value("result_valid_o", result_valid_o, 1);
    check_value("illegal_o", illegal_o, 0);
    check_value("result_rd_o", result_rd_o, rd);
    check_value("result_o", result_o, expected);
    if (rd != 5'd0) begin
      shadow[rd] = expected;
    end
  endtask

  task automatic run_r(input logic [2:0] funct3, input logic alt, input logic [4:0] rs1,
                       input logic [4:0] rs2, input logic [4:0] rd);
    logic [31:0] exp;
    exp = expected_alu(funct3, alt, shadow[rs1], shadow[rs2]);
    run_legal(encode_r(alt ? 7'h20 : 7'h00, rs2, rs1, funct3, rd), rd, exp);
  endtask

  task automatic run_i(input logic [2:0] funct3, input logic [11:0] imm, input logic [4:0] rs1,
                       input logic [4:0] rd);
    logic        alt;
    logic [31:0] exp;
    alt = (funct3 == 3'd5) && imm[10];
    exp = expected_alu(funct3, alt, shadow[rs1], sign_extend(imm));
    run_legal(encode_i(imm, rs1, funct3, rd), rd, exp);
  endtask

  ////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////

  task automatic test_reset_fill();
    logic [31:0] rnd;
    check_value("result_valid_o", result_valid_o, 0);
    check_value("illegal_o", illegal_o, 0);
    check_value("result_rd_o", result_rd_o, 0);
    check_value("result_o", result_o, 0);
    for (int r = 1; r < 32; r++) begin
      rnd = $random(seed);
      run_i(3'd0, rnd[11:0], 5'd0, 5'(r));
    end
  endtask

  task automatic test_r_type();
    logic [2:0] f3s  [10];
    logic       alts [10];
    f3s  = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
    alts = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0};
    for (int rep = 0; rep < 3; rep++) begin
      for (int k = 0; k < 10; k++) begin
        run_r(f3s[k], alts[k], pick_reg(), pick_reg(), pick_reg());
      end
    end
  endtask

  task automatic test_i_type();
    logic [2:0]  f3s [6];
    logic [31:0] rnd;
    f3s = '{3'd0, 3'd2, 3'd3, 3'd4, 3'd6, 3'd7};
    for (int rep = 0; rep < 3; rep++) begin
      for (int k = 0; k < 6; k++) begin
        rnd = $random(seed);
        run_i(f3s[k], rnd[11:0], pick_reg(), pick_reg());
      end
      rnd = $random(seed);
      run_i(3'd1, {7'h00, rnd[4:0]}, pick_reg(), pick_reg());
      run_i(3'd5, {7'h00, rnd[9:5]}, pick_reg(), pick_reg());
      run_i(3'd5, {7'h20, rnd[14:10]}, pick_reg(), pick_reg());
    end
    // negative operands for SRAI: -2048 >> 4 and 0x80000000 >> 31.
    run_legal(encode_i(12'h800, 5'd0, 3'd0, 5'd20), 5'd20, 32'hffff_f800);
    run_legal(encode_i({7'h20, 5'd4}, 5'd20, 3'd5, 5'd21), 5'd21, 32'hffff_ff80);
    run_legal(encode_i(12'h001, 5'd0, 3'd0, 5'd22), 5'd22, 32'h0000_0001);
    run_legal(encode_i({7'h00, 5'd31}, 5'd22, 3'd1, 5'd22), 5'd22, 32'h8000_0000);
    run_legal(encode_i({7'h20, 5'd31}, 5'd22, 3'd5, 5'd23), 5'd23, 32'hffff_ffff);
  endtask

  task automatic test_x0_write();
    run_r(3'd0, 1'b0, 5'd1, 5'd2, 5'd0);
    run_legal(encode_i(12'h000, 5'd0, 3'd0, 5'd7), 5'd7, 32'h0);
  endtask

  task automatic test_back_to_back();
    logic [31:0] words [CHAIN_LEN];
    logic [4:0]  rds   [CHAIN_LEN];
    logic [31:0] exps  [CHAIN_LEN];
    logic [31:0] rnd;
    logic [4:0]  rd;
    for (int i = 0; i < CHAIN_LEN; i++) begin
      rd  = 5'(10 + i);
      rnd = $random(seed);
      if (i % 2 == 0) begin
        words[i] = encode_i(rnd[11:0], (i == 0) ? 5'd0 : rd - 5'd1, 3'd0, rd);
        exps[i]  = ((i == 0) ? 32'h0 : shadow[rd - 5'd1]) + sign_extend(rnd[11:0]);
      end else begin
        words[i] = encode_r(7'h00, rd - 5'd2, rd - 5'd1, 3'd0, rd);
        exps[i]  = shadow[rd - 5'd1] + shadow[rd - 5'd2];
      end
      rds[i]     = rd;
      shadow[rd] = exps[i];
    end
    @(posedge clk_i);
    #2;
    instr_valid_i = 1'b1;
    instr_i       = words[0];
    for (int i = 1; i <= CHAIN_LEN; i++) begin
      @(posedge clk_i);
      #2;
      check_value("result_valid_o", result_valid_o, 1);
      check_value("result_rd_o", result_rd_o, rds[i-1]);
      check_value("result_o", result_o, exps[i-1]);
      if (i < CHAIN_LEN) begin
        instr_i = words[i];
      end else begin
        instr_valid_i = 1'b0;
      end
    end
  endtask

  task automatic illegal_case(input logic [31:0] word, input logic [4:0] rd);
    issue(word);
    check_value("illegal_o", illegal_o, 1);
    check_value("result_valid_o", result_valid_o, 0);
    // the target register must still hold its old value.
    run_legal(encode_i(12'h000, rd, 3'd0, 5'd31), 5'd31, shadow[rd]);
  endtask

  task automatic test_illegal();
    illegal_case({12'h000, 5'd1, 3'd0, 5'd3, 7'b1110011}, 5'd3);
    illegal_case(encode_r(7'h01, 5'd2, 5'd1, 3'd0, 5'd4), 5'd4);
    illegal_case(encode_r(7'h20, 5'd2, 5'd1, 3'd4, 5'd5), 5'd5);
    illegal_case(encode_i({7'h20, 5'd3}, 5'd1, 3'd1, 5'd6), 5'd6);
  endtask

  initial begin
    seed          = 32'h517;
    clk_i         = 1'b0;
    rst_n_i       = 1'b0;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    for (int r = 0; r < 32; r++) begin
      shadow[r] = 32'h0;
    end
    repeat (2) @(posedge clk_i);
    #2;
    rst_n_i = 1'b1;

    test_reset_fill();
    test_r_type();
    test_i_type();
    test_x0_write();
    test_back_to_back();
    test_illegal();

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/instr_decoder.sv
// Instruction decoder for the OP and OP-IMM groups.
// Produces the decoded operation and an illegal flag, combinationally.

`timescale 1ns/10ps
`default_nettype none

module instr_decoder (
  input  rv_exec_pkg::instr_u   instr_i,
  output rv_exec_pkg::exec_op_t op_o,
  output logic                  illegal_o
);

  // funct3 plus the alternate bit (instruction bit 30) select the ALU function.
  function automatic rv_exec_pkg::alu_op_e alu_from_funct3(
    input logic [2:0] funct3,
    input logic       alt
  );
    rv_exec_pkg::alu_op_e op;
    case (funct3)
      rv_exec_pkg::F3_ADD:  op = alt ? rv_exec_pkg::ALU_SUB : rv_exec_pkg::ALU_ADD;
      rv_exec_pkg::F3_SLL:  op = rv_exec_pkg::ALU_SLL;
      rv_exec_pkg::F3_SLT:  op = rv_exec_pkg::ALU_SLT;
      rv_exec_pkg::F3_SLTU: op = rv_exec_pkg::ALU_SLTU;
      rv_exec_pkg::F3_XOR:  op = rv_exec_pkg::ALU_XOR;
      rv_exec_pkg::F3_SR:   op = alt ? rv_exec_pkg::ALU_SRA : rv_exec_pkg::ALU_SRL;
      rv_exec_pkg::F3_OR:   op = rv_exec_pkg::ALU_OR;
      default:              op = rv_exec_pkg::ALU_AND;
    endcase
    return op;
  endfunction

  logic       is_op;
  logic       is_op_imm;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic [6:0] imm_hi;
  logic       alt_ok;
  logic       funct7_ok;
  logic       shift_ok;

  assign is_op     = (instr_i.r.opcode == rv_exec_pkg::OPC_OP);
  assign is_op_imm = (instr_i.r.opcode == rv_exec_pkg::OPC_OP_IMM);
  assign funct3    = instr_i.r.funct3;
  assign funct7    = instr_i.r.funct7;

  // for shift immediates the upper seven immediate bits play the role of funct7.
  assign imm_hi = instr_i.i.imm[11:5];

  // only SUB and SRA may use the alternate encoding.
  assign alt_ok = (funct3 == rv_exec_pkg::F3_ADD) || (funct3 == rv_exec_pkg::F3_SR);

  assign funct7_ok = (funct7 == 7'h00) || ((funct7 == 7'h20) && alt_ok);

  always_comb begin
    case (funct3)
      rv_exec_pkg::F3_SLL: shift_ok = (imm_hi == 7'h00);
      rv_exec_pkg::F3_SR:  shift_ok = (imm_hi == 7'h00) || (imm_hi == 7'h20);
      default:             shift_ok = 1'b1;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // operation fields
  ////////////////////////////////////////////////////////////

  always_comb begin
    op_o         = '0;
    op_o.alu_op  = rv_exec_pkg::ALU_ADD;
    op_o.rs1     = instr_i.r.rs1;
    op_o.rd      = instr_i.r.rd;
    op_o.imm     = {{20{instr_i.i.imm[11]}}, instr_i.i.imm};
    illegal_o    = 1'b0;

    if (is_op) begin
      op_o.rs2    = instr_i.r.rs2;
      op_o.alu_op = alu_from_funct3(funct3, funct7[5]);
      illegal_o   = ~funct7_ok;
    end else if (is_op_imm) begin
      op_o.use_imm = 1'b1;
      // bit 30 only means SRAI. For ADDI it is just an immediate bit.
      op_o.alu_op  = alu_from_funct3(funct3, (funct3 == rv_exec_pkg::F3_SR) & imm_hi[5]);
      illegal_o    = ~shift_ok;
    end else begin
      illegal_o = 1'b1;
    end

    // writes to x0 are still enabled here; the register file ignores them on read.
    op_o.write_en = ~illegal_o;
  end

endmodule

`default_nettype wire

// File: verilog/int_alu.sv
// Integer ALU for the RV32I OP and OP-IMM groups.
// Selects the second operand and computes the ten base functions.

`timescale 1ns/10ps
`default_nettype none

module int_alu (
  input  rv_exec_pkg::exec_op_t op_i,
  input  rv_exec_pkg::xlen_t    rs1_data_i,
  input  rv_exec_pkg::xlen_t    rs2_data_i,
  output rv_exec_pkg::xlen_t    result_o
);

  rv_exec_pkg::xlen_t operand_a;
  rv_exec_pkg::xlen_t operand_b;
  logic [4:0]         shamt;
  logic               lt_signed;
  logic               lt_unsigned;

  assign operand_a = rs1_data_i;

  // immediate forms take the sign-extended immediate in place of rs2.
  assign operand_b = op_i.use_imm ? op_i.imm : rs2_data_i;

  // shift amounts use only the low five bits, for both register and immediate forms.
  assign shamt = operand_b[4:0];

  assign lt_signed   = $signed(operand_a) < $signed(operand_b);
  assign lt_unsigned = operand_a < operand_b;

  ////////////////////////////////////////////////////////////
  // function select
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (op_i.alu_op)
      rv_exec_pkg::ALU_ADD:  result_o = operand_a + operand_b;
      rv_exec_pkg::ALU_SUB:  result_o = operand_a - operand_b;
      rv_exec_pkg::ALU_SLL:  result_o = operand_a << shamt;
      rv_exec_pkg::ALU_SLT:  result_o = {31'b0, lt_signed};
      rv_exec_pkg::ALU_SLTU: result_o = {31'b0, lt_unsigned};
      rv_exec_pkg::ALU_XOR:  result_o = operand_a ^ operand_b;
      rv_exec_pkg::ALU_SRL:  result_o = operand_a >> shamt;
      rv_exec_pkg::ALU_SRA:  result_o = $unsigned($signed(operand_a) >>> shamt);
      rv_exec_pkg::ALU_OR:   result_o = operand_a | operand_b;
      rv_exec_pkg::ALU_AND:  result_o = operand_a & operand_b;
      default:               result_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: verilog/int_exec_unit.sv
// Top level of the RV32I integer execution unit.
// Connects decoder, register file, ALU and writeback stage.

`timescale 1ns/10ps
`default_nettype none

module int_exec_unit (
  input  logic                   clk_i,
  input  logic                   rst_n_i,

  input  logic                   instr_valid_i,
  input  rv_exec_pkg::instr_u    instr_i,

  output logic                   result_valid_o,
  output rv_exec_pkg::reg_addr_t result_rd_o,
  output rv_exec_pkg::xlen_t     result_o,
  output logic                   illegal_o
);

  rv_exec_pkg::exec_op_t dec_op;
  logic                  dec_illegal;
  rv_exec_pkg::xlen_t    rs1_data;
  rv_exec_pkg::xlen_t    rs2_data;
  rv_exec_pkg::xlen_t    alu_result;
  rv_exec_pkg::wb_t      wb;

  instr_decoder u_decoder (
    .instr_i   (instr_i),
    .op_o      (dec_op),
    .illegal_o (dec_illegal)
  );

  register_file u_regfile (
    .clk_i          (clk_i),
    .write_enable_i (wb.we),
    .write_addr_i   (wb.rd),
    .read_addr1_i   (dec_op.rs1),
    .read_addr2_i   (dec_op.rs2),
    .write_data_i   (wb.data),
    .read_data1_o   (rs1_data),
    .read_data2_o   (rs2_data)
  );

  int_alu u_alu (
    .op_i       (dec_op),
    .rs1_data_i (rs1_data),
    .rs2_data_i (rs2_data),
    .result_o   (alu_result)
  );

  writeback_stage u_writeback (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .instr_valid_i  (instr_valid_i),
    .illegal_i      (dec_illegal),
    .rd_i           (dec_op.rd),
    .result_i       (alu_result),
    .wb_o           (wb),
    .result_valid_o (result_valid_o),
    .result_rd_o    (result_rd_o),
    .result_o       (result_o),
    .illegal_o      (illegal_o)
  );

endmodule

`default_nettype wire

// File: verilog/register_file.sv
// 32-entry integer register file.
// One write port, two combinational read ports, x0 reads zero.

`timescale 1ns/10ps
`default_nettype none

module register_file (
  input  logic                   clk_i,
  input  logic                   write_enable_i,

  input  rv_exec_pkg::reg_addr_t write_addr_i,
  input  rv_exec_pkg::reg_addr_t read_addr1_i,
  input  rv_exec_pkg::reg_addr_t read_addr2_i,

  input  rv_exec_pkg::xlen_t     write_data_i,
  output rv_exec_pkg::xlen_t     read_data1_o,
  output rv_exec_pkg::xlen_t     read_data2_o
);

  rv_exec_pkg::xlen_t rf_mem [32];

  // entry 0 may be written, but every read of address 0 is forced to zero.
  always_ff @(posedge clk_i) begin
    if (write_enable_i) begin
      rf_mem[write_addr_i] <= write_data_i;
    end
  end

  always_comb begin
    if (read_addr1_i == '0) begin
      read_data1_o = '0;
    end else begin
      read_data1_o = rf_mem[read_addr1_i];
    end
  end

  always_comb begin
    if (read_addr2_i == '0) begin
      read_data2_o = '0;
    end else begin
      read_data2_o = rf_mem[read_addr2_i];
    end
  end

endmodule

`default_nettype wire

// File: verilog/rv_exec_pkg.sv
// Shared types for the RV32I integer execution unit.
// Holds the instruction word views, opcode and funct3 codes,
// the ALU operation set, the decoded operation and the writeback record.

`default_nettype none

package rv_exec_pkg;

  ////////////////////////////////////////////////////////////
  // basic words
  ////////////////////////////////////////////////////////////

  typedef logic [31:0] xlen_t;
  typedef logic [4:0]  reg_addr_t;

  // register-register format.
  typedef struct packed {
    logic [6:0] funct7;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    reg_addr_t  rd;
    logic [6:0] opcode;
  } instr_r_t;

  // register-immediate format.
  typedef struct packed {
    logic [11:0] imm;
    reg_addr_t   rs1;
    logic [2:0]  funct3;
    reg_addr_t   rd;
    logic [6:0]  opcode;
  } instr_i_t;

  // the same 32-bit word seen as either format.
  typedef union packed {
    instr_r_t r;
    instr_i_t i;
  } instr_u;

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

  // funct3 codes shared by OP and OP-IMM.
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101;
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  ////////////////////////////////////////////////////////////
  // decoded operation and writeback
  ////////////////////////////////////////////////////////////

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND
  } alu_op_e;

  typedef struct packed {
    alu_op_e   alu_op;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    logic      use_imm;
    xlen_t     imm;
    logic      write_en;
  } exec_op_t;

  typedef struct packed {
    logic      we;
    reg_addr_t rd;
    xlen_t     data;
  } wb_t;

endpackage

`default_nettype wire

// File: verilog/writeback_stage.sv
// Writeback stage.
// Forms the register-file write and registers the result outputs.

`timescale 1ns/10ps
`default_nettype none

module writeback_stage (
  input  logic                   clk_i,
  input  logic                   rst_n_i,

  input  logic                   instr_valid_i,
  input  logic                   illegal_i,
  input  rv_exec_pkg::reg_addr_t rd_i,
  input  rv_exec_pkg::xlen_t     result_i,

  output rv_exec_pkg::wb_t       wb_o,

  output logic                   result_valid_o,
  output rv_exec_pkg::reg_addr_t result_rd_o,
  output rv_exec_pkg::xlen_t     result_o,
  output logic                   illegal_o
);

  logic take;

  // a strobed, legal instruction commits its result.
  assign take = instr_valid_i & ~illegal_i;

  // the register file captures at the same edge as the output flops,
  // so the next strobed instruction already reads this result.
  assign wb_o.we   = take;
  assign wb_o.rd   = rd_i;
  assign wb_o.data = result_i;

  ////////////////////////////////////////////////////////////
  // output registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      result_valid_o <= 1'b0;
      illegal_o      <= 1'b0;
      result_rd_o    <= '0;
      result_o       <= '0;
    end else begin
      result_valid_o <= take;
      illegal_o      <= instr_valid_i & illegal_i;
      // data outputs keep the last committed result between pulses.
      if (take) begin
        result_rd_o <= rd_i;
        result_o    <= result_i;
      end
    end
  end

endmodule

`default_nettype wire
